/* verilog.f */
design/core_pkg.sv
design/insn_decoder.sv
design/alu_exec.sv
design/reorder_buffer.sv
design/arch_regfile.sv
design/ooo_core_top.sv
testbench/tb_ooo_core.sv

/* Bender.yml */
package:
  name: ooo_core

sources:
  - files:
      - design/core_pkg.sv
      - design/insn_decoder.sv
      - design/alu_exec.sv
      - design/reorder_buffer.sv
      - design/arch_regfile.sv
      - design/ooo_core_top.sv
  - target: test
    files:
      - testbench/tb_ooo_core.sv

/* testbench/tb_ooo_core.sv */
`timescale 1ns/1ps

module tb_ooo_core;

    localparam int XLEN = 32;
    // shallow ROB so a MUL flood can fill it
    localparam int DEPTH = 4;
    localparam int CLK_PERIOD = 20;
    localparam int DRIVE_DLY = 2;
    localparam int N_RAND = 60;
    localparam int N_CHAIN = 20;
    localparam int N_FLOOD = 16;
    localparam int N_INSN = 6 + (31 + N_RAND) + N_CHAIN + 5 + (2 + N_FLOOD);
    localparam int TIMEOUT_CYCLES = 10 * N_INSN + 200;

    localparam logic [6:0] OPC_OP  = 7'b0110011;
    localparam logic [6:0] OPC_IMM = 7'b0010011;
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;
    localparam logic [6:0] F7_MUL  = 7'b0000001;

    logic            clk_i = 1'b0;
    logic            reset_i;
    logic            insn_valid_i;
    logic [31:0]     insn_i;
    logic [XLEN-1:0] pc_i;
    logic            stall_o;
    logic            commit_valid_o;
    logic [XLEN-1:0] commit_pc_o;
    logic            commit_we_o;
    logic [4:0]      commit_rd_o;
    logic [XLEN-1:0] commit_data_o;

    integer          seed;
    int              errors = 0;
    int              wr_ptr = 0;
    int              rd_ptr = 0;
    int              cycle_cnt = 0;
    int              full_cycles = 0;
    int              n_tests = 0;
    int              err_mark;
    int              insn_mark;
    logic [XLEN-1:0] next_pc;
    logic [XLEN-1:0] model_regs [32];

    // expected commit stream, indexed by program order
    logic [XLEN-1:0] exp_pc   [512];
    logic            exp_we   [512];
    logic [4:0]      exp_rd   [512];
    logic [XLEN-1:0] exp_data [512];

    ooo_core_top #(
        .XLEN      (XLEN),
        .ROB_DEPTH (DEPTH)
    ) i_ooo_core_top (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .insn_valid_i   (insn_valid_i),
        .insn_i         (insn_i),
        .pc_i           (pc_i),
        .stall_o        (stall_o),
        .commit_valid_o (commit_valid_o),
        .commit_pc_o    (commit_pc_o),
        .commit_we_o    (commit_we_o),
        .commit_rd_o    (commit_rd_o),
        .commit_data_o  (commit_data_o)
    );

    always begin
        #(CLK_PERIOD / 2);
        clk_i = ~clk_i;
    end

    // accepted and committed counts track the DUT occupancy
    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (!reset_i) begin
            if (insn_valid_i && !stall_o) begin
                wr_ptr <= wr_ptr + 1;
            end
            if (commit_valid_o) begin
                rd_ptr <= rd_ptr + 1;
            end
            if (wr_ptr - rd_ptr == DEPTH) begin
                full_cycles <= full_cycles + 1;
            end
        end
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("run timed out after %0d cycles, %0d of %0d instructions committed",
                     cycle_cnt, rd_ptr, wr_ptr);
            $display("TEST FAIL");
            $finish;
        end
    end

    a_idle: assert property (@(posedge clk_i) disable iff (reset_i)
        wr_ptr == 0 |-> !commit_valid_o && !stall_o)
        else begin
            $display("commit or stall raised before any instruction was accepted");
            errors++;
        end

    a_known: assert property (@(posedge clk_i) disable iff (reset_i)
        commit_valid_o |-> rd_ptr < wr_ptr)
        else begin
            $display("commit seen with no instruction outstanding");
            errors++;
        end

    a_pc: assert property (@(posedge clk_i) disable iff (reset_i)
        commit_valid_o |-> commit_pc_o == exp_pc[rd_ptr])
        else begin
            $display("FAIL commit_pc_o got %h expected %h",
                     $sampled(commit_pc_o), exp_pc[$sampled(rd_ptr)]);
            errors++;
        end

    a_we: assert property (@(posedge clk_i) disable iff (reset_i)
        commit_valid_o |-> commit_we_o == exp_we[rd_ptr])
        else begin
            $display("FAIL commit_we_o got %h expected %h",
                     $sampled(commit_we_o), exp_we[$sampled(rd_ptr)]);
            errors++;
        end

    a_rd: assert property (@(posedge clk_i) disable iff (reset_i)
        commit_valid_o && exp_we[rd_ptr] |-> commit_rd_o == exp_rd[rd_ptr])
        else begin
            $display("FAIL commit_rd_o got %h expected %h",
                     $sampled(commit_rd_o), exp_rd[$sampled(rd_ptr)]);
            errors++;
        end

    a_data: assert property (@(posedge clk_i) disable iff (reset_i)
        commit_valid_o && exp_we[rd_ptr] |-> commit_data_o == exp_data[rd_ptr])
        else begin
            $display("FAIL commit_data_o got %h expected %h",
                     $sampled(commit_data_o), exp_data[$sampled(rd_ptr)]);
            errors++;
        end

    a_full: assert property (@(posedge clk_i) disable iff (reset_i)
        wr_ptr - rd_ptr == DEPTH |-> stall_o)
        else begin
            $display("ROB full but stall_o low");
            errors++;
        end

    function automatic logic [31:0] rtype_insn(input logic [6:0] f7, input logic [2:0] f3,
                                               input logic [4:0] rd, input logic [4:0] rs1,
                                               input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] addi_insn(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, OPC_IMM};
    endfunction

    function automatic logic [31:0] random_insn(input logic [4:0] rd, input logic [4:0] rs1,
                                                input logic [4:0] rs2);
        int sel;
        sel = $unsigned($random(seed)) % 7;
        case (sel)
            0: return rtype_insn(F7_BASE, 3'b000, rd, rs1, rs2);
            1: return rtype_insn(F7_SUB, 3'b000, rd, rs1, rs2);
            2: return rtype_insn(F7_BASE, 3'b111, rd, rs1, rs2);
            3: return rtype_insn(F7_BASE, 3'b110, rd, rs1, rs2);
            4: return rtype_insn(F7_BASE, 3'b100, rd, rs1, rs2);
            5: return rtype_insn(F7_MUL, 3'b000, rd, rs1, rs2);
            default: return addi_insn(rd, rs1, 12'($random(seed)));
        endcase
    endfunction

    function automatic logic [4:0] random_reg(input int lo);
        return 5'(lo + $unsigned($random(seed)) % (32 - lo));
    endfunction

    // ISA result from the model registers, in program order
    task automatic record_expect(input logic [31:0] insn);
        logic [2:0]      f3;
        logic [6:0]      f7;
        logic [4:0]      rd;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] res;
        logic            known;
        f3 = insn[14:12];
        f7 = insn[31:25];
        rd = insn[11:7];
        a = model_regs[insn[19:15]];
        b = model_regs[insn[24:20]];
        known = 1'b1;
        res = '0;
        if (insn[6:0] == OPC_IMM && f3 == 3'b000) begin
            res = a + {{(XLEN-12){insn[31]}}, insn[31:20]};
        end else if (insn[6:0] == OPC_OP && f7 == F7_BASE && f3 == 3'b000) begin
            res = a + b;
        end else if (insn[6:0] == OPC_OP && f7 == F7_SUB && f3 == 3'b000) begin
            res = a - b;
        end else if (insn[6:0] == OPC_OP && f7 == F7_BASE && f3 == 3'b111) begin
            res = a & b;
        end else if (insn[6:0] == OPC_OP && f7 == F7_BASE && f3 == 3'b110) begin
            res = a | b;
        end else if (insn[6:0] == OPC_OP && f7 == F7_BASE && f3 == 3'b100) begin
            res = a ^ b;
        end else if (insn[6:0] == OPC_OP && f7 == F7_MUL && f3 == 3'b000) begin
            res = a * b;
        end else begin
            known = 1'b0;
        end
        exp_pc[wr_ptr] = pc_i;
        exp_we[wr_ptr] = known && (rd != 5'd0);
        exp_rd[wr_ptr] = rd;
        exp_data[wr_ptr] = res;
        if (known && rd != 5'd0) begin
            model_regs[rd] = res;
        end
        next_pc = next_pc + 4;
    endtask

    // hold the instruction until a mid-cycle look shows no stall
    task automatic send_insn(input logic [31:0] insn);
        insn_valid_i = 1'b1;
        insn_i = insn;
        pc_i = next_pc;
        @(negedge clk_i);
        while (stall_o) begin
            @(negedge clk_i);
        end
        record_expect(insn);
        @(posedge clk_i);
        #DRIVE_DLY;
        insn_valid_i = 1'b0;
    endtask

    task automatic begin_test();
        err_mark = errors;
        insn_mark = wr_ptr;
    endtask

    task automatic finish_test(input string name);
        while (rd_ptr != wr_ptr) begin
            @(posedge clk_i);
        end
        repeat (2) @(posedge clk_i);
        #DRIVE_DLY;
        n_tests++;
        $display("test %-16s %3d insns  %0d errors", name, wr_ptr - insn_mark, errors - err_mark);
    endtask

    initial begin
        logic [4:0] prev;
        logic [4:0] rd;
        int         full_mark;
        seed = 32'h4fa12ea0;
        reset_i = 1'b1;
        insn_valid_i = 1'b0;
        insn_i = '0;
        pc_i = '0;
        next_pc = 32'h0000_1000;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (10) @(posedge clk_i);
        #DRIVE_DLY;
        reset_i = 1'b0;

        begin_test();
        repeat (20) @(posedge clk_i);
        finish_test("reset_idle");

        // MUL first, younger fast ops finish before it but retire after
        begin_test();
        send_insn(addi_insn(5'd1, 5'd0, 12'h123));
        send_insn(addi_insn(5'd2, 5'd0, 12'hf05));
        send_insn(rtype_insn(F7_MUL, 3'b000, 5'd5, 5'd1, 5'd2));
        send_insn(rtype_insn(F7_BASE, 3'b000, 5'd6, 5'd1, 5'd2));
        send_insn(rtype_insn(F7_BASE, 3'b100, 5'd7, 5'd1, 5'd2));
        send_insn(rtype_insn(F7_BASE, 3'b110, 5'd9, 5'd2, 5'd1));
        finish_test("mul_then_adds");

        begin_test();
        for (int i = 1; i < 32; i++) begin
            send_insn(addi_insn(5'(i), 5'd0, 12'($random(seed))));
        end
        for (int i = 0; i < N_RAND; i++) begin
            send_insn(random_insn(random_reg(1), random_reg(0), random_reg(0)));
        end
        finish_test("random_alu");

        begin_test();
        prev = 5'd3;
        for (int i = 0; i < N_CHAIN; i++) begin
            rd = 5'(11 + i % 4);
            send_insn(random_insn(rd, prev, random_reg(1)));
            prev = rd;
        end
        finish_test("dependent_chain");

        // x0 target, unknown opcode with rd 5, then reads of x0
        begin_test();
        send_insn(rtype_insn(F7_BASE, 3'b000, 5'd0, 5'd1, 5'd2));
        send_insn(32'h0000_02ff);
        send_insn(addi_insn(5'd0, 5'd0, 12'h005));
        send_insn(rtype_insn(F7_BASE, 3'b000, 5'd8, 5'd0, 5'd3));
        send_insn(addi_insn(5'd9, 5'd0, 12'h123));
        finish_test("x0_and_unknown");

        begin_test();
        full_mark = full_cycles;
        send_insn(addi_insn(5'd25, 5'd0, 12'h2a7));
        send_insn(addi_insn(5'd26, 5'd0, 12'h9c3));
        for (int i = 0; i < N_FLOOD; i++) begin
            send_insn(rtype_insn(F7_MUL, 3'b000, 5'(1 + i), 5'd25, 5'd26));
        end
        finish_test("mul_flood");
        if (full_cycles == full_mark) begin
            $display("ROB never filled during the MUL flood");
            errors++;
        end

        $display("%0d tests, %0d instructions, %0d errors", n_tests, wr_ptr, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* design/ooo_core_top.sv */
`timescale 1ns/1ps

module ooo_core_top import core_pkg::*; #(
    parameter int  XLEN      = 32,
    parameter int  ROB_DEPTH = 8,
    localparam int ROB_SEL   = $clog2(ROB_DEPTH)
) (
    input  logic            clk_i,
    input  logic            reset_i,
    input  logic            insn_valid_i,
    input  logic [31:0]     insn_i,
    input  logic [XLEN-1:0] pc_i,
    output logic            stall_o,
    output logic            commit_valid_o,
    output logic [XLEN-1:0] commit_pc_o,
    output logic            commit_we_o,
    output logic [4:0]      commit_rd_o,
    output logic [XLEN-1:0] commit_data_o
);

    // operand read
    logic [4:0]         rs1_addr;
    logic [4:0]         rs2_addr;
    logic [XLEN-1:0]    rs1_data;
    logic [XLEN-1:0]    rs2_data;

    // dispatch into the ROB
    logic               disp_valid;
    logic [ROB_SEL-1:0] disp_tag;
    logic [XLEN-1:0]    disp_pc;
    logic [4:0]         disp_rd;
    logic               disp_we;

    // issue to execute
    logic               issue_valid;
    alu_op_e            issue_op;
    logic [ROB_SEL-1:0] issue_tag;
    logic [XLEN-1:0]    issue_a;
    logic [XLEN-1:0]    issue_b;

    // finish back to the ROB
    logic               finish_valid;
    logic [ROB_SEL-1:0] finish_tag;
    logic [XLEN-1:0]    finish_data;

    insn_decoder #(
        .XLEN      (XLEN),
        .ROB_DEPTH (ROB_DEPTH)
    ) i_insn_decoder (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .insn_valid_i   (insn_valid_i),
        .insn_i         (insn_i),
        .pc_i           (pc_i),
        .rs1_data_i     (rs1_data),
        .rs2_data_i     (rs2_data),
        .commit_valid_i (commit_valid_o),
        .commit_we_i    (commit_we_o),
        .commit_rd_i    (commit_rd_o),
        .stall_o        (stall_o),
        .rs1_addr_o     (rs1_addr),
        .rs2_addr_o     (rs2_addr),
        .disp_valid_o   (disp_valid),
        .disp_tag_o     (disp_tag),
        .disp_pc_o      (disp_pc),
        .disp_rd_o      (disp_rd),
        .disp_we_o      (disp_we),
        .issue_valid_o  (issue_valid),
        .issue_op_o     (issue_op),
        .issue_tag_o    (issue_tag),
        .issue_a_o      (issue_a),
        .issue_b_o      (issue_b)
    );

    alu_exec #(
        .XLEN      (XLEN),
        .ROB_DEPTH (ROB_DEPTH)
    ) i_alu_exec (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .issue_valid_i  (issue_valid),
        .issue_op_i     (issue_op),
        .issue_tag_i    (issue_tag),
        .issue_a_i      (issue_a),
        .issue_b_i      (issue_b),
        .finish_valid_o (finish_valid),
        .finish_tag_o   (finish_tag),
        .finish_data_o  (finish_data)
    );

    reorder_buffer #(
        .XLEN      (XLEN),
        .ROB_DEPTH (ROB_DEPTH)
    ) i_reorder_buffer (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .disp_valid_i   (disp_valid),
        .disp_tag_i     (disp_tag),
        .disp_pc_i      (disp_pc),
        .disp_rd_i      (disp_rd),
        .disp_we_i      (disp_we),
        .finish_valid_i (finish_valid),
        .finish_tag_i   (finish_tag),
        .finish_data_i  (finish_data),
        .commit_valid_o (commit_valid_o),
        .commit_pc_o    (commit_pc_o),
        .commit_we_o    (commit_we_o),
        .commit_rd_o    (commit_rd_o),
        .commit_data_o  (commit_data_o)
    );

    arch_regfile #(
        .XLEN (XLEN)
    ) i_arch_regfile (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .we_i       (commit_we_o),
        .rd_i       (commit_rd_o),
        .wdata_i    (commit_data_o),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

endmodule

/* design/arch_regfile.sv */
`timescale 1ns/1ps

module arch_regfile #(
    parameter int XLEN = 32
) (
    input  logic            clk_i,
    input  logic            reset_i,
    input  logic [4:0]      rs1_addr_i,
    input  logic [4:0]      rs2_addr_i,
    input  logic            we_i,
    input  logic [4:0]      rd_i,
    input  logic [XLEN-1:0] wdata_i,
    output logic [XLEN-1:0] rs1_data_o,
    output logic [XLEN-1:0] rs2_data_o
);

    logic [XLEN-1:0] regs_q [32];

    // committed state only, written in program order
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            regs_q <= '{default: '0};
        end else if (we_i && (rd_i != 5'd0)) begin
            regs_q[rd_i] <= wdata_i;
        end
    end

    // x0 hardwired to zero
    assign rs1_data_o = (rs1_addr_i == 5'd0) ? '0 : regs_q[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == 5'd0) ? '0 : regs_q[rs2_addr_i];

endmodule

/* design/reorder_buffer.sv */
`timescale 1ns/1ps

module reorder_buffer #(
    parameter int  XLEN      = 32,
    parameter int  ROB_DEPTH = 8,
    localparam int ROB_SEL   = $clog2(ROB_DEPTH)
) (
    input  logic               clk_i,
    input  logic               reset_i,
    input  logic               disp_valid_i,
    input  logic [ROB_SEL-1:0] disp_tag_i,
    input  logic [XLEN-1:0]    disp_pc_i,
    input  logic [4:0]         disp_rd_i,
    input  logic               disp_we_i,
    input  logic               finish_valid_i,
    input  logic [ROB_SEL-1:0] finish_tag_i,
    input  logic [XLEN-1:0]    finish_data_i,
    output logic               commit_valid_o,
    output logic [XLEN-1:0]    commit_pc_o,
    output logic               commit_we_o,
    output logic [4:0]         commit_rd_o,
    output logic [XLEN-1:0]    commit_data_o
);

    // per-entry state flags
    logic [ROB_DEPTH-1:0] valid_q;
    logic [ROB_DEPTH-1:0] finish_q;
    logic [ROB_DEPTH-1:0] dst_we_q;

    // per-entry payload
    logic [XLEN-1:0]      pc_q   [ROB_DEPTH];
    logic [4:0]           rd_q   [ROB_DEPTH];
    logic [XLEN-1:0]      data_q [ROB_DEPTH];

    logic [ROB_SEL-1:0]   head_q;
    logic                 commit;

    // oldest entry retires once its result is in
    assign commit = valid_q[head_q] && finish_q[head_q];

    assign commit_valid_o = commit;
    assign commit_pc_o    = pc_q[head_q];
    assign commit_we_o    = commit && dst_we_q[head_q];
    assign commit_rd_o    = rd_q[head_q];
    assign commit_data_o  = data_q[head_q];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q  <= '0;
            finish_q <= '0;
            head_q   <= '0;
        end else begin
            if (disp_valid_i) begin
                valid_q[disp_tag_i]  <= 1'b1;
                finish_q[disp_tag_i] <= 1'b0;
            end
            if (finish_valid_i) begin
                finish_q[finish_tag_i] <= 1'b1;
            end
            if (commit) begin
                valid_q[head_q] <= 1'b0;
                // depth is a power of two, wrap is free
                head_q <= head_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (disp_valid_i) begin
            pc_q[disp_tag_i]     <= disp_pc_i;
            rd_q[disp_tag_i]     <= disp_rd_i;
            dst_we_q[disp_tag_i] <= disp_we_i;
        end
        if (finish_valid_i) begin
            data_q[finish_tag_i] <= finish_data_i;
        end
    end

    // tail never catches up with a live entry
    a_disp_free: assert property (@(posedge clk_i) disable iff (reset_i)
        disp_valid_i |-> !valid_q[disp_tag_i]);

    // each dispatched entry finishes exactly once
    a_finish_live: assert property (@(posedge clk_i) disable iff (reset_i)
        finish_valid_i |-> valid_q[finish_tag_i] && !finish_q[finish_tag_i]);

endmodule

/* design/alu_exec.sv */
`timescale 1ns/1ps

module alu_exec import core_pkg::*; #(
    parameter int  XLEN      = 32,
    parameter int  ROB_DEPTH = 8,
    localparam int ROB_SEL   = $clog2(ROB_DEPTH)
) (
    input  logic               clk_i,
    input  logic               reset_i,
    input  logic               issue_valid_i,
    input  alu_op_e            issue_op_i,
    input  logic [ROB_SEL-1:0] issue_tag_i,
    input  logic [XLEN-1:0]    issue_a_i,
    input  logic [XLEN-1:0]    issue_b_i,
    output logic               finish_valid_o,
    output logic [ROB_SEL-1:0] finish_tag_o,
    output logic [XLEN-1:0]    finish_data_o
);

    localparam int HALF = XLEN / 2;
    // the issue register counts as the first multiply stage
    localparam int MUL_STAGES = MUL_LATENCY - 1;

    logic                  fast_valid;
    logic [XLEN-1:0]       fast_data;
    logic                  mul_issue;
    logic                  mul_done;

    logic [MUL_STAGES-1:0] mul_vld_q;
    logic [ROB_SEL-1:0]    mul_tag_q [MUL_STAGES];
    logic [XLEN-1:0]       pp_lo_q;
    logic [XLEN-1:0]       pp_hi_q;
    logic [XLEN-1:0]       mul_prod_q [1:MUL_STAGES-1];

    // fast lane, finishes in its issue cycle
    always_comb begin
        case (issue_op_i)
            OP_SUB:  fast_data = issue_a_i - issue_b_i;
            OP_AND:  fast_data = issue_a_i & issue_b_i;
            OP_OR:   fast_data = issue_a_i | issue_b_i;
            OP_XOR:  fast_data = issue_a_i ^ issue_b_i;
            default: fast_data = issue_a_i + issue_b_i;
        endcase
    end

    assign fast_valid = issue_valid_i && (issue_op_i != OP_MUL);
    assign mul_issue  = issue_valid_i && (issue_op_i == OP_MUL);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mul_vld_q <= '0;
        end else begin
            mul_vld_q <= {mul_vld_q[MUL_STAGES-2:0], mul_issue};
        end
    end

    // multiply split on the halves of b, low XLEN bits kept throughout
    always_ff @(posedge clk_i) begin
        if (mul_issue) begin
            mul_tag_q[0] <= issue_tag_i;
            pp_lo_q      <= issue_a_i * {{(XLEN-HALF){1'b0}}, issue_b_i[HALF-1:0]};
            pp_hi_q      <= issue_a_i * {{HALF{1'b0}}, issue_b_i[XLEN-1:HALF]};
        end
        mul_prod_q[1] <= pp_lo_q + (pp_hi_q << HALF);
        for (int i = 1; i < MUL_STAGES; i++) begin
            mul_tag_q[i] <= mul_tag_q[i-1];
        end
        for (int i = 2; i < MUL_STAGES; i++) begin
            mul_prod_q[i] <= mul_prod_q[i-1];
        end
    end

    assign mul_done = mul_vld_q[MUL_STAGES-1];

    // decoder reserves the finish slot, so at most one lane is valid
    assign finish_valid_o = fast_valid || mul_done;
    assign finish_tag_o   = mul_done ? mul_tag_q[MUL_STAGES-1] : issue_tag_i;
    assign finish_data_o  = mul_done ? mul_prod_q[MUL_STAGES-1] : fast_data;

    a_one_lane: assert property (@(posedge clk_i) disable iff (reset_i)
        !(fast_valid && mul_done));

endmodule

/* design/insn_decoder.sv */
`timescale 1ns/1ps

module insn_decoder import core_pkg::*; #(
    parameter int  XLEN      = 32,
    parameter int  ROB_DEPTH = 8,
    localparam int ROB_SEL   = $clog2(ROB_DEPTH)
) (
    input  logic               clk_i,
    input  logic               reset_i,
    input  logic               insn_valid_i,
    input  logic [31:0]        insn_i,
    input  logic [XLEN-1:0]    pc_i,
    input  logic [XLEN-1:0]    rs1_data_i,
    input  logic [XLEN-1:0]    rs2_data_i,
    input  logic               commit_valid_i,
    input  logic               commit_we_i,
    input  logic [4:0]         commit_rd_i,
    output logic               stall_o,
    output logic [4:0]         rs1_addr_o,
    output logic [4:0]         rs2_addr_o,
    output logic               disp_valid_o,
    output logic [ROB_SEL-1:0] disp_tag_o,
    output logic [XLEN-1:0]    disp_pc_o,
    output logic [4:0]         disp_rd_o,
    output logic               disp_we_o,
    output logic               issue_valid_o,
    output alu_op_e            issue_op_o,
    output logic [ROB_SEL-1:0] issue_tag_o,
    output logic [XLEN-1:0]    issue_a_o,
    output logic [XLEN-1:0]    issue_b_o
);

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    // a fast op accepted this many cycles after a MUL would share its finish cycle
    localparam int RESV_W = MUL_LATENCY - FAST_LATENCY;

    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic [6:0]         funct7;
    logic [4:0]         rd;
    logic [XLEN-1:0]    imm;
    alu_op_e            dec_op;
    logic               known;
    logic               is_imm;
    logic               writes_rd;
    logic               fast_op;
    logic               hazard;
    logic               collide;
    logic               full;
    logic               accept;

    logic [31:0]        pending_q;
    logic [ROB_SEL:0]   occ_q;
    logic [ROB_SEL-1:0] tail_q;
    logic [RESV_W-1:0]  resv_q;
    logic               issue_valid_q;
    alu_op_e            issue_op_q;
    logic [ROB_SEL-1:0] issue_tag_q;
    logic [XLEN-1:0]    issue_a_q;
    logic [XLEN-1:0]    issue_b_q;

    assign opcode = insn_i[6:0];
    assign funct3 = insn_i[14:12];
    assign funct7 = insn_i[31:25];
    assign rd     = insn_i[11:7];
    assign imm    = {{(XLEN-12){insn_i[31]}}, insn_i[31:20]};

    // unknown encodings fall through as ADD so the entry still finishes
    always_comb begin
        dec_op = OP_ADD;
        known  = 1'b0;
        is_imm = 1'b0;
        if (opcode == OPC_OP) begin
            known = 1'b1;
            case ({funct7, funct3})
                {7'b0000000, 3'b000}: dec_op = OP_ADD;
                {7'b0100000, 3'b000}: dec_op = OP_SUB;
                {7'b0000000, 3'b111}: dec_op = OP_AND;
                {7'b0000000, 3'b110}: dec_op = OP_OR;
                {7'b0000000, 3'b100}: dec_op = OP_XOR;
                {7'b0000001, 3'b000}: dec_op = OP_MUL;
                default:              known  = 1'b0;
            endcase
        end else if (opcode == OPC_OP_IMM && funct3 == 3'b000) begin
            known  = 1'b1;
            is_imm = 1'b1;
        end
    end

    assign writes_rd = known && (rd != 5'd0);
    assign fast_op   = (dec_op != OP_MUL);

    // no forwarding, so wait out any in-flight producer or writer
    assign hazard = (known && pending_q[insn_i[19:15]])
                 || (known && !is_imm && pending_q[insn_i[24:20]])
                 || (writes_rd && pending_q[rd]);
    assign collide = fast_op && resv_q[0];
    assign full    = (occ_q == (ROB_SEL+1)'(ROB_DEPTH));
    assign stall_o = full || (insn_valid_i && (hazard || collide));
    assign accept  = insn_valid_i && !stall_o;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pending_q     <= '0;
            occ_q         <= '0;
            tail_q        <= '0;
            resv_q        <= '0;
            issue_valid_q <= 1'b0;
        end else begin
            if (commit_valid_i && commit_we_i) begin
                pending_q[commit_rd_i] <= 1'b0;
            end
            if (accept && writes_rd) begin
                pending_q[rd] <= 1'b1;
            end
            if (accept && !commit_valid_i) begin
                occ_q <= occ_q + 1'b1;
            end else if (!accept && commit_valid_i) begin
                occ_q <= occ_q - 1'b1;
            end
            if (accept) begin
                tail_q <= tail_q + 1'b1;
            end
            // MUL finish slot walks down towards bit 0
            resv_q        <= {accept && !fast_op, resv_q[RESV_W-1:1]};
            issue_valid_q <= accept;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            issue_op_q  <= dec_op;
            issue_tag_q <= tail_q;
            issue_a_q   <= rs1_data_i;
            issue_b_q   <= is_imm ? imm : rs2_data_i;
        end
    end

    assign rs1_addr_o    = insn_i[19:15];
    assign rs2_addr_o    = insn_i[24:20];
    assign disp_valid_o  = accept;
    assign disp_tag_o    = tail_q;
    assign disp_pc_o     = pc_i;
    assign disp_rd_o     = rd;
    assign disp_we_o     = writes_rd;
    assign issue_valid_o = issue_valid_q;
    assign issue_op_o    = issue_op_q;
    assign issue_tag_o   = issue_tag_q;
    assign issue_a_o     = issue_a_q;
    assign issue_b_o     = issue_b_q;

    a_occ_bound: assert property (@(posedge clk_i) disable iff (reset_i)
        occ_q <= (ROB_SEL+1)'(ROB_DEPTH));

    // a fast op never dispatches into the finish cycle of an earlier MUL
    a_finish_slot: assert property (@(posedge clk_i) disable iff (reset_i)
        disp_valid_o && !fast_op |-> ##RESV_W !(disp_valid_o && fast_op));

endmodule

/* design/core_pkg.sv */
package core_pkg;

    // operation code carried from decode to the execute lanes
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_MUL = 3'd5
    } alu_op_e;

    // finish delay of each lane, counted from the accept cycle
    // the issue register is the first stage of both lanes
    localparam int FAST_LATENCY = 1;
    localparam int MUL_LATENCY  = 4;

endpackage
